// ==== common/axi_pkg.sv ====
package axi_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int STRB_W = DATA_W / 8;

    // ~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    // ~~~~~~~~~~~~~~~~~~~~
    // Channel payloads
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;   // Beats minus one
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic [ID_W-1:0]   id;
    } axi_r_t;

    typedef struct packed {
        logic [1:0]      resp;
        logic [ID_W-1:0] id;
    } axi_b_t;

endpackage

// ==== common/soc_map_pkg.sv ====
package soc_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~
    localparam logic [15:0] CLINT_BASE_HI = 16'h0200;  // 0x0200_0000 to 0x0200_FFFF
    localparam logic [15:0] MTIME_LO_OFS  = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS  = 16'hBFFC;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // ~~~~~~~~~~~~~~~~~~~~
    // Timer count
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } mtime_words_t;

    // Counted as one word, read back as two halves
    typedef union packed {
        logic [63:0]  count;
        mtime_words_t words;
    } mtime_u;

endpackage

// ==== arbiter/bus_arbiter.sv ====
module bus_arbiter (
    input  logic             clk,
    input  logic             rst,

    input  axi_pkg::axi_ar_t ifu_ar,
    input  logic             ifu_arvalid,
    output logic             ifu_arready,
    output axi_pkg::axi_r_t  ifu_r,
    output logic             ifu_rvalid,
    input  logic             ifu_rready,

    input  axi_pkg::axi_aw_t lsu_aw,
    input  logic             lsu_awvalid,
    output logic             lsu_awready,
    input  axi_pkg::axi_w_t  lsu_w,
    input  logic             lsu_wvalid,
    output logic             lsu_wready,
    output axi_pkg::axi_b_t  lsu_b,
    output logic             lsu_bvalid,
    input  logic             lsu_bready,
    input  axi_pkg::axi_ar_t lsu_ar,
    input  logic             lsu_arvalid,
    output logic             lsu_arready,
    output axi_pkg::axi_r_t  lsu_r,
    output logic             lsu_rvalid,
    input  logic             lsu_rready,

    output axi_pkg::axi_aw_t mem_aw,
    output logic             mem_awvalid,
    input  logic             mem_awready,
    output axi_pkg::axi_w_t  mem_w,
    output logic             mem_wvalid,
    input  logic             mem_wready,
    input  axi_pkg::axi_b_t  mem_b,
    input  logic             mem_bvalid,
    output logic             mem_bready,
    output axi_pkg::axi_ar_t mem_ar,
    output logic             mem_arvalid,
    input  logic             mem_arready,
    input  axi_pkg::axi_r_t  mem_r,
    input  logic             mem_rvalid,
    output logic             mem_rready,

    output axi_pkg::axi_ar_t clint_ar,
    output logic             clint_arvalid,
    input  logic             clint_arready,
    input  axi_pkg::axi_r_t  clint_r,
    input  logic             clint_rvalid,
    output logic             clint_rready
);
    import soc_map_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        GNT_IFU,
        GNT_LSU
    } grant_e;

    grant_e grant;
    grant_e grant_next;
    logic   is_clint;
    logic   ifu_done;
    logic   lsu_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant    <= IDLE;
            is_clint <= 1'b0;
        end else begin
            grant <= grant_next;
            if (grant == IDLE) begin
                is_clint <= lsu_arvalid && (lsu_ar.addr[31:16] == CLINT_BASE_HI);
            end
        end
    end

    assign ifu_done = mem_rvalid && ifu_rready && mem_r.last;
    assign lsu_done = is_clint ? (clint_rvalid && lsu_rready)
                               : ((mem_rvalid && lsu_rready && mem_r.last) ||
                                  (mem_bvalid && lsu_bready));

    always_comb begin
        grant_next = grant;
        case (grant)
            IDLE: begin
                if (lsu_arvalid || lsu_awvalid) begin
                    grant_next = GNT_LSU;  // Data side first
                end else if (ifu_arvalid) begin
                    grant_next = GNT_IFU;
                end
            end
            GNT_IFU: begin
                if (ifu_done) begin
                    grant_next = IDLE;
                end
            end
            GNT_LSU: begin
                if (lsu_done) begin
                    grant_next = IDLE;
                end
            end
            default: grant_next = IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Channel steering
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ifu_arready   = 1'b0;
        ifu_r         = '0;
        ifu_rvalid    = 1'b0;
        lsu_awready   = 1'b0;
        lsu_wready    = 1'b0;
        lsu_b         = '0;
        lsu_bvalid    = 1'b0;
        lsu_arready   = 1'b0;
        lsu_r         = '0;
        lsu_rvalid    = 1'b0;
        mem_aw        = '0;
        mem_awvalid   = 1'b0;
        mem_w         = '0;
        mem_wvalid    = 1'b0;
        mem_bready    = 1'b0;
        mem_ar        = '0;
        mem_arvalid   = 1'b0;
        mem_rready    = 1'b0;
        clint_ar      = '0;
        clint_arvalid = 1'b0;
        clint_rready  = 1'b0;
        case (grant)
            GNT_IFU: begin
                mem_ar      = ifu_ar;
                mem_arvalid = ifu_arvalid;
                ifu_arready = mem_arready;
                ifu_r       = mem_r;
                ifu_rvalid  = mem_rvalid;
                mem_rready  = ifu_rready;
            end
            GNT_LSU: begin
                mem_aw      = lsu_aw;  // Writes always land in memory
                mem_awvalid = lsu_awvalid;
                lsu_awready = mem_awready;
                mem_w       = lsu_w;
                mem_wvalid  = lsu_wvalid;
                lsu_wready  = mem_wready;
                lsu_b       = mem_b;
                lsu_bvalid  = mem_bvalid;
                mem_bready  = lsu_bready;
                if (is_clint) begin
                    clint_ar      = lsu_ar;
                    clint_arvalid = lsu_arvalid;
                    lsu_arready   = clint_arready;
                    lsu_r         = clint_r;
                    lsu_rvalid    = clint_rvalid;
                    clint_rready  = lsu_rready;
                end else begin
                    mem_ar      = lsu_ar;
                    mem_arvalid = lsu_arvalid;
                    lsu_arready = mem_arready;
                    lsu_r       = mem_r;
                    lsu_rvalid  = mem_rvalid;
                    mem_rready  = lsu_rready;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== clint/clint_timer.sv ====
module clint_timer (
    input  logic             clk,
    input  logic             rst,
    input  axi_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready
);
    import axi_pkg::*;
    import soc_map_pkg::*;

    mtime_u mtime;
    logic   ar_fire;

    assign arready = !rvalid;  // One read at a time
    assign ar_fire = arvalid && arready;

    // ~~~~~~~~~~~~~~~~~~~~
    // Counter and handshake
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime.count <= '0;
            rvalid      <= 1'b0;
        end else begin
            mtime.count <= mtime.count + 64'd1;
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read data
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r.id   <= ar.id;
            r.last <= 1'b1;  // Always single beat
            case (ar.addr[15:0])
                MTIME_LO_OFS: begin
                    r.data <= mtime.words.lo;
                    r.resp <= RESP_OKAY;
                end
                MTIME_HI_OFS: begin
                    r.data <= mtime.words.hi;
                    r.resp <= RESP_OKAY;
                end
                default: begin
                    r.data <= '0;
                    r.resp <= RESP_SLVERR;  // Unmapped offset
                end
            endcase
        end
    end

endmodule

// ==== source/axi_sram.sv ====
module axi_sram (
    input  logic             clk,
    input  logic             rst,
    input  axi_pkg::axi_aw_t aw,
    input  logic             awvalid,
    output logic             awready,
    input  axi_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output axi_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready,
    input  axi_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output axi_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready
);
    import axi_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_RESP
    } sram_state_e;

    sram_state_e       state;
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        burst_q;
    logic [ID_W-1:0]   id_q;
    logic [7:0]        beats_left;  // Beats after the one on the bus
    logic [DATA_W-1:0] rd_data;
    logic              aw_fire;
    logic              w_fire;
    logic              ar_fire;
    logic              r_fire;

    function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] addr,
                                                    input logic [1:0]        burst);
        logic [ADDR_W-1:0] nxt;
        case (burst)
            BURST_INCR:  nxt = addr + ADDR_W'(4);
            BURST_FIXED: nxt = addr;
            default:     nxt = addr;
        endcase
        return nxt;
    endfunction

    function automatic logic [MEM_IDX_W-1:0] word_idx(input logic [ADDR_W-1:0] addr);
        return addr[MEM_IDX_W+1:2];  // Upper bits alias
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshakes
    // ~~~~~~~~~~~~~~~~~~~~
    assign awready = (state == S_IDLE);
    assign arready = (state == S_IDLE) && !awvalid;  // Write wins a tie
    assign wready  = (state == S_WRITE);
    assign rvalid  = (state == S_READ);
    assign bvalid  = (state == S_RESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    assign r = '{data: rd_data, resp: RESP_OKAY, last: (beats_left == 8'd0), id: id_q};
    assign b = '{resp: RESP_OKAY, id: id_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            beats_left <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_fire) begin
                        state <= S_WRITE;
                    end else if (ar_fire) begin
                        state      <= S_READ;
                        beats_left <= ar.len;
                    end
                end
                S_READ: begin
                    if (r_fire) begin
                        if (beats_left == 8'd0) begin
                            state <= S_IDLE;
                        end else begin
                            beats_left <= beats_left - 8'd1;
                        end
                    end
                end
                S_WRITE: begin
                    if (w_fire && w.last) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (bready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Array and burst address
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            addr_q  <= aw.addr;
            burst_q <= aw.burst;
            id_q    <= aw.id;
        end
        if (ar_fire) begin
            addr_q  <= next_addr(ar.addr, ar.burst);  // Points at the second beat
            burst_q <= ar.burst;
            id_q    <= ar.id;
            rd_data <= mem[word_idx(ar.addr)];
        end
        if (r_fire && beats_left != 8'd0) begin
            addr_q  <= next_addr(addr_q, burst_q);
            rd_data <= mem[word_idx(addr_q)];
        end
        if (w_fire) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[word_idx(addr_q)][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
            addr_q <= next_addr(addr_q, burst_q);
        end
    end

endmodule

// ==== source/soc_bus_top.sv ====
module soc_bus_top (
    input  logic             clk,
    input  logic             rst,

    input  axi_pkg::axi_ar_t ifu_ar,
    input  logic             ifu_arvalid,
    output logic             ifu_arready,
    output axi_pkg::axi_r_t  ifu_r,
    output logic             ifu_rvalid,
    input  logic             ifu_rready,

    input  axi_pkg::axi_aw_t lsu_aw,
    input  logic             lsu_awvalid,
    output logic             lsu_awready,
    input  axi_pkg::axi_w_t  lsu_w,
    input  logic             lsu_wvalid,
    output logic             lsu_wready,
    output axi_pkg::axi_b_t  lsu_b,
    output logic             lsu_bvalid,
    input  logic             lsu_bready,
    input  axi_pkg::axi_ar_t lsu_ar,
    input  logic             lsu_arvalid,
    output logic             lsu_arready,
    output axi_pkg::axi_r_t  lsu_r,
    output logic             lsu_rvalid,
    input  logic             lsu_rready
);
    import axi_pkg::*;

    // Memory side
    axi_aw_t mem_aw;
    logic    mem_awvalid;
    logic    mem_awready;
    axi_w_t  mem_w;
    logic    mem_wvalid;
    logic    mem_wready;
    axi_b_t  mem_b;
    logic    mem_bvalid;
    logic    mem_bready;
    axi_ar_t mem_ar;
    logic    mem_arvalid;
    logic    mem_arready;
    axi_r_t  mem_r;
    logic    mem_rvalid;
    logic    mem_rready;

    // Timer side
    axi_ar_t clint_ar;
    logic    clint_arvalid;
    logic    clint_arready;
    axi_r_t  clint_r;
    logic    clint_rvalid;
    logic    clint_rready;

    bus_arbiter u_arbiter (.*);

    axi_sram u_sram (
        .clk     (clk),
        .rst     (rst),
        .aw      (mem_aw),
        .awvalid (mem_awvalid),
        .awready (mem_awready),
        .w       (mem_w),
        .wvalid  (mem_wvalid),
        .wready  (mem_wready),
        .b       (mem_b),
        .bvalid  (mem_bvalid),
        .bready  (mem_bready),
        .ar      (mem_ar),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .r       (mem_r),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready)
    );

    clint_timer u_clint (
        .clk     (clk),
        .rst     (rst),
        .ar      (clint_ar),
        .arvalid (clint_arvalid),
        .arready (clint_arready),
        .r       (clint_r),
        .rvalid  (clint_rvalid),
        .rready  (clint_rready)
    );

endmodule

// ==== bench/soc_bus_chk.sv ====
module soc_bus_chk (
    input logic            clk,
    input logic            rst,
    input logic            ifu_rvalid,
    input logic            lsu_rvalid,
    input logic            mem_arvalid,
    input logic            clint_arvalid,
    input axi_pkg::axi_r_t mem_r,
    input logic            mem_rvalid,
    input logic            mem_rready,
    input axi_pkg::axi_r_t clint_r,
    input logic            clint_rvalid,
    input logic            clint_rready
);
    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // Grant exclusivity
    // ~~~~~~~~~~~~~~~~~~~~
    one_reader: assert property (@(posedge clk) disable iff (rst) !(ifu_rvalid && lsu_rvalid))
        else $error("IFU and LSU read data valid in the same cycle");

    one_target: assert property (@(posedge clk) disable iff (rst) !(mem_arvalid && clint_arvalid))
        else $error("Read request forwarded to memory and CLINT together");

    // ~~~~~~~~~~~~~~~~~~~~
    // Held read beats
    // ~~~~~~~~~~~~~~~~~~~~
    mem_r_held: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid && !mem_rready |=> $stable(mem_r))
        else $error("Memory read beat changed while stalled");

    clint_r_held: assert property (@(posedge clk) disable iff (rst)
        clint_rvalid && !clint_rready |=> $stable(clint_r))
        else $error("CLINT read beat changed while stalled");

endmodule

bind bus_arbiter soc_bus_chk u_chk (.*);

// ==== bench/soc_bus_tb.sv ====
module soc_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;
    import soc_map_pkg::*;

    localparam int          MAX_CYCLES = 6000;  // About three times the test length
    localparam logic [31:0] SEED       = 32'hb311e06e;

    logic    clk;
    logic    rst;
    axi_ar_t ifu_ar;
    logic    ifu_arvalid;
    logic    ifu_arready;
    axi_r_t  ifu_r;
    logic    ifu_rvalid;
    logic    ifu_rready;
    axi_aw_t lsu_aw;
    logic    lsu_awvalid;
    logic    lsu_awready;
    axi_w_t  lsu_w;
    logic    lsu_wvalid;
    logic    lsu_wready;
    axi_b_t  lsu_b;
    logic    lsu_bvalid;
    logic    lsu_bready;
    axi_ar_t lsu_ar;
    logic    lsu_arvalid;
    logic    lsu_arready;
    axi_r_t  lsu_r;
    logic    lsu_rvalid;
    logic    lsu_rready;

    logic [DATA_W-1:0] shadow [MEM_WORDS];  // Expected memory image
    string             test_name;
    int unsigned       stall_pct;
    int                cycle;
    int                beat_errors;
    int                seq_errors;

    // Compare process state
    axi_ar_t           ifu_req;
    axi_ar_t           lsu_req;
    int                ifu_beat;
    int                lsu_beat;
    bit                ifu_open;
    bit                lsu_open;
    bit                ifu_rvalid_q;
    int                ifu_start_cyc;
    int                lsu_end_cyc;
    logic [DATA_W-1:0] lsu_last_data;

    soc_bus_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles with a transfer still waiting", cycle);
            $display("Errors: %0d beat, %0d sequence", beat_errors, seq_errors);
            $display("Verification failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        return shadow[addr[11:2]];  // Word index with upper bits aliased
    endfunction

    function automatic bit stall_now();
        return $urandom_range(99) < stall_pct;
    endfunction

    task automatic check_beat(input bit from_ifu, input axi_r_t got, input axi_ar_t req,
                              input int idx);
        string             port;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] exp_data;
        logic [1:0]        exp_resp;
        bit                exp_last;
        bit                data_known;
        port       = from_ifu ? "IFU" : "LSU";
        addr       = (req.burst == BURST_INCR) ? req.addr + 32'(4 * idx) : req.addr;
        exp_data   = expected_word(addr);
        exp_resp   = RESP_OKAY;
        exp_last   = (idx == int'(req.len));
        data_known = 1'b1;
        if (!from_ifu && req.addr[31:16] == CLINT_BASE_HI) begin
            exp_data = '0;  // mtime high half and unmapped offsets
            if (req.addr[15:0] == MTIME_LO_OFS) begin
                data_known = 1'b0;  // Live count
            end else if (req.addr[15:0] != MTIME_HI_OFS) begin
                exp_resp = RESP_SLVERR;
            end
        end
        if (data_known && got.data !== exp_data) begin
            $display("[FAIL] %s %s beat %0d data: expected %h, actual %h",
                     test_name, port, idx, exp_data, got.data);
            beat_errors++;
        end
        if (got.resp !== exp_resp) begin
            $display("[FAIL] %s %s beat %0d resp: expected %h, actual %h",
                     test_name, port, idx, exp_resp, got.resp);
            beat_errors++;
        end
        if (got.id !== req.id) begin
            $display("[FAIL] %s %s beat %0d id: expected %h, actual %h",
                     test_name, port, idx, req.id, got.id);
            beat_errors++;
        end
        if (got.last !== exp_last) begin
            $display("[FAIL] %s %s beat %0d last: expected %b, actual %b",
                     test_name, port, idx, exp_last, got.last);
            beat_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare process
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst) begin
            if (ifu_arvalid && ifu_arready) begin
                ifu_req  = ifu_ar;
                ifu_beat = 0;
                ifu_open = 1'b1;
            end
            if (ifu_rvalid && !ifu_rvalid_q) begin
                ifu_start_cyc = cycle;
            end
            ifu_rvalid_q = ifu_rvalid;
            if (ifu_rvalid && ifu_rready) begin
                if (!ifu_open) begin
                    $display("IFU returned a read beat with no request open in %s", test_name);
                    beat_errors++;
                end else begin
                    check_beat(1'b1, ifu_r, ifu_req, ifu_beat);
                    ifu_beat++;
                    ifu_open = (ifu_beat <= int'(ifu_req.len));
                end
            end
            if (lsu_arvalid && lsu_arready) begin
                lsu_req  = lsu_ar;
                lsu_beat = 0;
                lsu_open = 1'b1;
            end
            if (lsu_rvalid && lsu_rready) begin
                lsu_end_cyc   = cycle;
                lsu_last_data = lsu_r.data;
                if (!lsu_open) begin
                    $display("LSU returned a read beat with no request open in %s", test_name);
                    beat_errors++;
                end else begin
                    check_beat(1'b0, lsu_r, lsu_req, lsu_beat);
                    lsu_beat++;
                    lsu_open = (lsu_beat <= int'(lsu_req.len));
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Manager drivers
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic lsu_write_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                                   input logic [ID_W-1:0] id, input bit rand_strb);
        logic [ADDR_W-1:0] a;
        axi_w_t            beat;
        bit                done;
        lsu_aw      = axi_aw_t'{addr: addr, id: id, len: len, size: 3'd2, burst: BURST_INCR};
        lsu_awvalid = 1'b1;
        do begin
            @(negedge clk);
        end while (!lsu_awready);
        @(posedge clk);
        #1;
        lsu_awvalid = 1'b0;
        a = addr;
        for (int i = 0; i <= int'(len); i++) begin
            beat.data  = $urandom;
            beat.strb  = rand_strb ? 4'($urandom) : 4'hf;
            beat.last  = (i == int'(len));
            lsu_w      = beat;
            lsu_wvalid = 1'b1;
            do begin
                @(negedge clk);
            end while (!lsu_wready);
            for (int k = 0; k < STRB_W; k++) begin
                if (beat.strb[k]) begin
                    shadow[a[11:2]][8*k +: 8] = beat.data[8*k +: 8];  // Byte merge
                end
            end
            a = a + 32'd4;
            @(posedge clk);
            #1;
        end
        lsu_wvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            lsu_bready = !stall_now();
            @(negedge clk);
            done = lsu_bvalid && lsu_bready;
            if (done && (lsu_b.resp !== RESP_OKAY || lsu_b.id !== id)) begin
                $display("[FAIL] %s write response: expected resp %h id %h, actual resp %h id %h",
                         test_name, RESP_OKAY, id, lsu_b.resp, lsu_b.id);
                seq_errors++;
            end
            @(posedge clk);
            #1;
        end
        lsu_bready = 1'b0;
    endtask

    task automatic read_burst(input bit from_ifu, input axi_ar_t req);
        int beats;
        bit fire;
        if (from_ifu) begin
            ifu_ar      = req;
            ifu_arvalid = 1'b1;
        end else begin
            lsu_ar      = req;
            lsu_arvalid = 1'b1;
        end
        do begin
            @(negedge clk);
        end while (!(from_ifu ? ifu_arready : lsu_arready));
        @(posedge clk);
        #1;
        if (from_ifu) begin
            ifu_arvalid = 1'b0;
        end else begin
            lsu_arvalid = 1'b0;
        end
        beats = 0;
        while (beats <= int'(req.len)) begin
            if (from_ifu) begin
                ifu_rready = !stall_now();
            end else begin
                lsu_rready = !stall_now();
            end
            @(negedge clk);
            fire = from_ifu ? (ifu_rvalid && ifu_rready) : (lsu_rvalid && lsu_rready);
            if (fire) begin
                beats++;
            end
            @(posedge clk);
            #1;
        end
        ifu_rready = from_ifu ? 1'b0 : ifu_rready;
        lsu_rready = from_ifu ? lsu_rready : 1'b0;
    endtask

    task automatic lsu_read_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                                  input logic [ID_W-1:0] id, input logic [1:0] burst);
        read_burst(1'b0, axi_ar_t'{addr: addr, id: id, len: len, size: 3'd2, burst: burst});
    endtask

    task automatic ifu_fetch_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                                   input logic [ID_W-1:0] id, input logic [1:0] burst);
        read_burst(1'b1, axi_ar_t'{addr: addr, id: id, len: len, size: 3'd2, burst: burst});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [ADDR_W-1:0] base;
        logic [7:0]        len;
        logic [DATA_W-1:0] mtime_first;
        void'($urandom(SEED));
        rst         = 1'b1;
        ifu_ar      = '0;
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b0;
        lsu_aw      = '0;
        lsu_awvalid = 1'b0;
        lsu_w       = '0;
        lsu_wvalid  = 1'b0;
        lsu_bready  = 1'b0;
        lsu_ar      = '0;
        lsu_arvalid = 1'b0;
        lsu_rready  = 1'b0;
        stall_pct   = 0;
        test_name   = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "preload";  // Words 0 to 63 with full strobes
        for (int i = 0; i < 4; i++) begin
            lsu_write_burst(32'(i * 64), 8'd15, 4'h1, 1'b0);
        end

        test_name = "lsu_write_read";
        for (int i = 0; i < 6; i++) begin
            base = 32'(($urandom % 56) * 4);
            len  = 8'($urandom % 8);
            lsu_write_burst(base, len, 4'(i), 1'b1);
            lsu_read_burst(base, len, 4'(i + 8), BURST_INCR);
        end

        test_name = "ifu_fetch";
        for (int i = 0; i < 6; i++) begin
            base = 32'(($urandom % 56) * 4);
            len  = 8'($urandom % 8);
            ifu_fetch_burst(base, len, 4'h5, (i % 2 == 0) ? BURST_INCR : BURST_FIXED);
        end

        test_name = "same_cycle";
        fork
            lsu_read_burst(32'h40, 8'd7, 4'h9, BURST_INCR);
            ifu_fetch_burst(32'h80, 8'd7, 4'h6, BURST_INCR);
        join
        if (ifu_start_cyc <= lsu_end_cyc) begin
            $display("IFU read data appeared before the LSU burst finished in %s", test_name);
            seq_errors++;
        end

        test_name = "clint";
        lsu_read_burst(32'h0200_BFF8, 8'd0, 4'h2, BURST_INCR);
        mtime_first = lsu_last_data;
        lsu_read_burst(32'h0200_BFF8, 8'd0, 4'h2, BURST_INCR);
        if (lsu_last_data <= mtime_first) begin
            $display("[FAIL] %s mtime: expected more than %h, actual %h",
                     test_name, mtime_first, lsu_last_data);
            seq_errors++;
        end
        lsu_read_burst(32'h0200_BFFC, 8'd0, 4'h3, BURST_INCR);
        lsu_read_burst(32'h0200_0000, 8'd0, 4'h4, BURST_INCR);
        lsu_read_burst(32'h0000_0000, 8'd3, 4'h4, BURST_INCR);

        test_name = "stalls";
        stall_pct = 50;
        for (int i = 0; i < 5; i++) begin
            base = 32'(($urandom % 56) * 4);
            len  = 8'($urandom % 8);
            lsu_write_burst(base, len, 4'hc, 1'b1);
            lsu_read_burst(base, len, 4'hd, BURST_INCR);
            ifu_fetch_burst(base, len, 4'he, BURST_INCR);
        end
        stall_pct = 0;

        $display("Errors: %0d beat, %0d sequence", beat_errors, seq_errors);
        if (beat_errors + seq_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== soc_bus.f ====
common/axi_pkg.sv
common/soc_map_pkg.sv
arbiter/bus_arbiter.sv
clint/clint_timer.sv
source/axi_sram.sv
source/soc_bus_top.sv
bench/soc_bus_chk.sv
bench/soc_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= soc_bus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
